/* common/rv_pkg.sv */
package rv_pkg;

    localparam logic [31:0] RESET_ADDR = 32'h0000_0000;
    localparam logic [31:0] TRAP_ADDR  = 32'h0000_0100;

    localparam int IADDR_BITS         = 16;
    localparam int FETCH_BUF_DEPTH    = 4;
    localparam int FETCH_BUF_PTR_BITS = $clog2(FETCH_BUF_DEPTH);

    typedef logic [FETCH_BUF_PTR_BITS-1:0] buf_ptr_t;
    typedef logic [FETCH_BUF_PTR_BITS:0]   buf_cnt_t;  // One extra bit to hold a full count.

    typedef enum logic [3:0]
    {
        OP_LUI,
        OP_ADDI,
        OP_XORI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_JAL,
        OP_BEQ,
        OP_BNE,
        OP_EBREAK,
        OP_ILLEGAL
    } rv_opcode_e;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS  // Operand b straight through.
    } rv_alu_e;

    typedef struct packed
    {
        rv_opcode_e  opcode;
        rv_alu_e     alu;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        valid;
    } rv_issue_t;

endpackage

/* common/rv_fetch_if.sv */
interface rv_fetch_if;

    logic                          valid;
    logic [31:0]                   instr;
    logic [rv_pkg::IADDR_BITS-1:0] pc;
    logic                          take;

    modport source
    (
        output valid,
        output instr,
        output pc,
        input  take
    );

    modport sink
    (
        input  valid,
        input  instr,
        input  pc,
        output take
    );

endinterface

/* common/rv_issue_if.sv */
interface rv_issue_if
(
    input logic i_clk,
    input logic i_rst
);

    rv_pkg::rv_issue_t issue;   // Registered slot from decode.
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
    logic              redirect;
    logic [31:0]       redirect_pc;
    logic              wb_valid;
    logic              wb_we;
    logic [4:0]        wb_rd;
    logic [31:0]       wb_data;
    logic [31:0]       retire_pc;
    logic              retire_trap;
    logic              retire_illegal;

    modport fetch (input redirect, input redirect_pc);

    modport decode (input redirect, output issue);

    modport execute
    (
        input  i_clk, i_rst, issue, rs1_data, rs2_data,
        output redirect, redirect_pc, wb_valid, wb_we, wb_rd, wb_data,
        output retire_pc, retire_trap, retire_illegal
    );

    modport result
    (
        input  issue, wb_valid, wb_we, wb_rd, wb_data,
        input  retire_pc, retire_trap, retire_illegal,
        output rs1_data, rs2_data
    );

endinterface

/* fetch/rv_fetch_buf.sv */
module rv_fetch_buf
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_flush,
    input  logic                          i_push,
    input  logic [31:0]                   i_data,
    input  logic [rv_pkg::IADDR_BITS-1:0] i_pc,
    input  logic                          i_pop,
    output logic [31:0]                   o_data,
    output logic [rv_pkg::IADDR_BITS-1:0] o_pc,
    output logic                          o_empty,
    output logic                          o_full
);

    logic [31:0]                   data_mem [rv_pkg::FETCH_BUF_DEPTH];
    logic [rv_pkg::IADDR_BITS-1:0] pc_mem   [rv_pkg::FETCH_BUF_DEPTH];

    rv_pkg::buf_ptr_t wr_ptr;
    rv_pkg::buf_ptr_t rd_ptr;
    rv_pkg::buf_cnt_t count;

    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            data_mem[wr_ptr] <= i_data;
            pc_mem[wr_ptr]   <= i_pc;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (i_push)
                wr_ptr <= wr_ptr + rv_pkg::buf_ptr_t'(1);  // Wraps at depth.
            if (i_pop)
                rd_ptr <= rd_ptr + rv_pkg::buf_ptr_t'(1);
            case ({i_push, i_pop})
                2'b10:   count <= count + rv_pkg::buf_cnt_t'(1);
                2'b01:   count <= count - rv_pkg::buf_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    assign o_data  = data_mem[rd_ptr];
    assign o_pc    = pc_mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == rv_pkg::buf_cnt_t'(rv_pkg::FETCH_BUF_DEPTH));

    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_push && o_full));
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_pop && o_empty));

endmodule

/* fetch/rv_fetch.sv */
module rv_fetch
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_ack,
    input  logic [31:0]                   i_instruction,
    output logic                          o_cyc,
    output logic [rv_pkg::IADDR_BITS-1:0] o_addr,
    rv_fetch_if.source                    fetch_if,
    rv_issue_if.fetch                     issue_if
);

    logic [rv_pkg::IADDR_BITS-1:0] pc;
    logic [rv_pkg::IADDR_BITS-1:0] pc_next;
    logic                          run;
    logic                          accept;
    logic                          push;
    logic                          empty;
    logic                          full;

    assign accept = o_cyc && i_ack;
    assign push   = accept && !issue_if.redirect;  // Word in flight is stale on redirect.

    always_comb
    begin
        if (i_rst)
            pc_next = rv_pkg::RESET_ADDR[rv_pkg::IADDR_BITS-1:0];
        else if (issue_if.redirect)
            pc_next = issue_if.redirect_pc[rv_pkg::IADDR_BITS-1:0];
        else if (accept)
            pc_next = pc + rv_pkg::IADDR_BITS'(4);
        else
            pc_next = pc;   // Bus stall holds the pc.
    end

    always_ff @(posedge i_clk)
    begin
        pc <= pc_next;
        if (i_rst)
            run <= 1'b0;
        else
            run <= 1'b1;
    end

    rv_fetch_buf u_buf
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_flush (issue_if.redirect),
        .i_push  (push),
        .i_data  (i_instruction),
        .i_pc    (pc),
        .i_pop   (fetch_if.take),
        .o_data  (fetch_if.instr),
        .o_pc    (fetch_if.pc),
        .o_empty (empty),
        .o_full  (full)
    );

    assign fetch_if.valid = !empty;
    assign o_cyc          = run && !full;
    assign o_addr         = pc;

    // Redirect targets come from execute, so alignment is checked at the bus.
    a_addr_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        o_cyc |-> (o_addr[1:0] == 2'b00));

endmodule

/* logic/rv_decode.sv */
module rv_decode
(
    input  logic       i_clk,
    input  logic       i_rst,
    rv_fetch_if.sink   fetch_if,
    rv_issue_if.decode issue_if
);

    logic [31:0]        instr;
    logic [31:0]        imm_i;
    logic [31:0]        imm_u;
    logic [31:0]        imm_b;
    logic [31:0]        imm_j;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv_pkg::rv_issue_t  dec;
    rv_pkg::rv_issue_t  slot;

    assign instr  = fetch_if.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign fetch_if.take = fetch_if.valid && !issue_if.redirect;

    always_comb
    begin
        dec.opcode = rv_pkg::OP_ILLEGAL;
        dec.alu    = rv_pkg::ALU_ADD;
        dec.imm    = imm_i;
        case (instr[6:0])
            7'b0110111:
            begin
                dec.opcode = rv_pkg::OP_LUI;
                dec.alu    = rv_pkg::ALU_PASS;
                dec.imm    = imm_u;
            end
            7'b0010011:
            begin
                if (funct3 == 3'b000)
                    dec.opcode = rv_pkg::OP_ADDI;
                else if (funct3 == 3'b100)
                begin
                    dec.opcode = rv_pkg::OP_XORI;
                    dec.alu    = rv_pkg::ALU_XOR;
                end
            end
            7'b0110011:
            begin
                case ({funct7, funct3})
                    10'b0000000_000: dec.opcode = rv_pkg::OP_ADD;
                    10'b0100000_000:
                    begin
                        dec.opcode = rv_pkg::OP_SUB;
                        dec.alu    = rv_pkg::ALU_SUB;
                    end
                    10'b0000000_111:
                    begin
                        dec.opcode = rv_pkg::OP_AND;
                        dec.alu    = rv_pkg::ALU_AND;
                    end
                    10'b0000000_110:
                    begin
                        dec.opcode = rv_pkg::OP_OR;
                        dec.alu    = rv_pkg::ALU_OR;
                    end
                    10'b0000000_100:
                    begin
                        dec.opcode = rv_pkg::OP_XOR;
                        dec.alu    = rv_pkg::ALU_XOR;
                    end
                    10'b0000000_010:
                    begin
                        dec.opcode = rv_pkg::OP_SLT;
                        dec.alu    = rv_pkg::ALU_SLT;
                    end
                    default: dec.opcode = rv_pkg::OP_ILLEGAL;
                endcase
            end
            7'b1101111:
            begin
                dec.opcode = rv_pkg::OP_JAL;
                dec.imm    = imm_j;
            end
            7'b1100011:
            begin
                dec.imm = imm_b;
                if (funct3 == 3'b000)
                    dec.opcode = rv_pkg::OP_BEQ;
                else if (funct3 == 3'b001)
                    dec.opcode = rv_pkg::OP_BNE;
            end
            7'b1110011:
            begin
                if (instr == 32'h0010_0073)
                    dec.opcode = rv_pkg::OP_EBREAK;
            end
            default: dec.opcode = rv_pkg::OP_ILLEGAL;
        endcase

        dec.rs1   = instr[19:15];
        dec.rs2   = instr[24:20];
        dec.rd    = instr[11:7];
        dec.pc    = 32'(fetch_if.pc);
        dec.valid = 1'b1;
        // Branches, EBREAK and illegal words leave the register file alone.
        dec.we    = (instr[11:7] != 5'd0) &&
                    !(dec.opcode inside {rv_pkg::OP_BEQ, rv_pkg::OP_BNE,
                                         rv_pkg::OP_EBREAK, rv_pkg::OP_ILLEGAL});
    end

    always_ff @(posedge i_clk)
    begin
        if (fetch_if.take)
            slot <= dec;
        if (i_rst || !fetch_if.take)
            slot.valid <= 1'b0;  // Bubble, also on redirect.
    end

    assign issue_if.issue = slot;

endmodule

/* logic/rv_execute.sv */
module rv_execute
(
    rv_issue_if.execute issue_if
);

    rv_pkg::rv_issue_t issue;
    logic [31:0]       op_a;
    logic [31:0]       op_b;
    logic [31:0]       alu_out;
    logic [31:0]       link;
    logic              imm_sel;
    logic              branch_taken;

    assign issue = issue_if.issue;
    assign link  = issue.pc + 32'd4;

    assign imm_sel = issue.opcode inside {rv_pkg::OP_LUI, rv_pkg::OP_ADDI, rv_pkg::OP_XORI};
    assign op_a    = issue_if.rs1_data;
    assign op_b    = imm_sel ? issue.imm : issue_if.rs2_data;

    always_comb
    begin
        case (issue.alu)
            rv_pkg::ALU_ADD:  alu_out = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_out = op_a - op_b;
            rv_pkg::ALU_AND:  alu_out = op_a & op_b;
            rv_pkg::ALU_OR:   alu_out = op_a | op_b;
            rv_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            rv_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_PASS: alu_out = op_b;
            default:          alu_out = '0;
        endcase
    end

    assign branch_taken = ((issue.opcode == rv_pkg::OP_BEQ) && (op_a == op_b)) ||
                          ((issue.opcode == rv_pkg::OP_BNE) && (op_a != op_b));

    assign issue_if.redirect = issue.valid &&
                               (branch_taken ||
                                (issue.opcode == rv_pkg::OP_JAL) ||
                                (issue.opcode == rv_pkg::OP_EBREAK));

    assign issue_if.redirect_pc = (issue.opcode == rv_pkg::OP_EBREAK) ?
                                  rv_pkg::TRAP_ADDR : issue.pc + issue.imm;

    assign issue_if.wb_valid = issue.valid;
    assign issue_if.wb_we    = issue.valid && issue.we;
    assign issue_if.wb_rd    = issue.rd;
    assign issue_if.wb_data  = (issue.opcode == rv_pkg::OP_JAL) ? link : alu_out;

    assign issue_if.retire_pc      = issue.pc;
    assign issue_if.retire_trap    = (issue.opcode == rv_pkg::OP_EBREAK);
    assign issue_if.retire_illegal = (issue.opcode == rv_pkg::OP_ILLEGAL);

    // B and J immediates may carry bit 1, so the program has to keep targets aligned.
    a_target_aligned: assert property (@(posedge issue_if.i_clk) disable iff (issue_if.i_rst)
        issue_if.redirect |-> (issue_if.redirect_pc[1:0] == 2'b00));

endmodule

/* logic/rv_result.sv */
module rv_result
(
    input  logic        i_clk,
    input  logic        i_rst,
    rv_issue_if.result  issue_if,
    output logic        o_retire_valid,
    output logic [31:0] o_retire_pc,
    output logic [4:0]  o_retire_rd,
    output logic [31:0] o_retire_data,
    output logic        o_retire_trap,
    output logic        o_retire_illegal
);

    logic [31:0] regs [1:31];

    // x0 reads as zero.
    assign issue_if.rs1_data = (issue_if.issue.rs1 == 5'd0) ? '0 : regs[issue_if.issue.rs1];
    assign issue_if.rs2_data = (issue_if.issue.rs2 == 5'd0) ? '0 : regs[issue_if.issue.rs2];

    always_ff @(posedge i_clk)
    begin
        if (issue_if.wb_we)
            regs[issue_if.wb_rd] <= issue_if.wb_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_retire_valid <= 1'b0;
        else
            o_retire_valid <= issue_if.wb_valid;
        if (issue_if.wb_valid)
        begin
            o_retire_pc      <= issue_if.retire_pc;
            o_retire_rd      <= issue_if.wb_we ? issue_if.wb_rd : 5'd0;   // Zero when nothing written.
            o_retire_data    <= issue_if.wb_we ? issue_if.wb_data : 32'd0;
            o_retire_trap    <= issue_if.retire_trap;
            o_retire_illegal <= issue_if.retire_illegal;
        end
    end

    a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
        issue_if.wb_we |-> (issue_if.wb_rd != 5'd0));

endmodule

/* logic/rv_core.sv */
module rv_core
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_ack,
    input  logic [31:0]                   i_instruction,
    output logic                          o_cyc,
    output logic [rv_pkg::IADDR_BITS-1:0] o_addr,
    output logic                          o_retire_valid,
    output logic [31:0]                   o_retire_pc,
    output logic [4:0]                    o_retire_rd,
    output logic [31:0]                   o_retire_data,
    output logic                          o_retire_trap,
    output logic                          o_retire_illegal
);

    rv_fetch_if fetch_if ();
    rv_issue_if issue_if (.i_clk(i_clk), .i_rst(i_rst));

    rv_fetch u_fetch
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ack         (i_ack),
        .i_instruction (i_instruction),
        .o_cyc         (o_cyc),
        .o_addr        (o_addr),
        .fetch_if      (fetch_if),
        .issue_if      (issue_if)
    );

    rv_decode u_decode
    (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .fetch_if (fetch_if),
        .issue_if (issue_if)
    );

    rv_execute u_execute (.issue_if(issue_if));

    rv_result u_result
    (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .issue_if         (issue_if),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_rd      (o_retire_rd),
        .o_retire_data    (o_retire_data),
        .o_retire_trap    (o_retire_trap),
        .o_retire_illegal (o_retire_illegal)
    );

endmodule

/* test/tb_rv_core.sv */
module tb_rv_core;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum
    {
        K_LUI, K_ADDI, K_XORI, K_ADD, K_SUB, K_AND, K_OR,
        K_XOR, K_SLT, K_JAL, K_BEQ, K_BNE, K_EBREAK, K_ILL
    } op_kind_e;

    localparam int MEM_WORDS    = 256;
    localparam int N_REC        = 23;   // Up to EBREAK, handler, three self-loop passes.
    localparam int ACK_MAX_WAIT = 6;
    localparam int WATCHDOG_CYCLES = 2 * N_REC * (ACK_MAX_WAIT + 1) * 8;

    localparam int T_RESET  = 0;
    localparam int T_ALU    = 1;
    localparam int T_BRANCH = 2;
    localparam int T_BP     = 3;
    localparam int T_TRAP   = 4;

    logic                          i_clk;
    logic                          i_rst;
    logic                          i_ack = 1'b0;
    logic [31:0]                   i_instruction = '0;
    logic                          o_cyc;
    logic [rv_pkg::IADDR_BITS-1:0] o_addr;
    logic                          o_retire_valid;
    logic [31:0]                   o_retire_pc;
    logic [4:0]                    o_retire_rd;
    logic [31:0]                   o_retire_data;
    logic                          o_retire_trap;
    logic                          o_retire_illegal;

    logic [31:0] mem       [MEM_WORDS];
    op_kind_e    prog_kind [MEM_WORDS];
    logic [4:0]  prog_rd   [MEM_WORDS];
    logic [4:0]  prog_rs1  [MEM_WORDS];
    logic [4:0]  prog_rs2  [MEM_WORDS];
    logic [31:0] prog_imm  [MEM_WORDS];

    logic [31:0] exp_pc   [N_REC+1];
    logic [4:0]  exp_rd   [N_REC+1];
    logic [31:0] exp_data [N_REC+1];
    logic        exp_trap [N_REC+1];
    logic        exp_ill  [N_REC+1];
    int          exp_test [N_REC+1];

    logic        random_ack = 1'b0;
    logic        rst_q      = 1'b0;
    logic        ack_now;
    logic [31:0] lfsr       = 32'h3d79_9546;
    int          ack_wait   = 0;
    int          chk_idx    = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_errs  [5] = '{default: 0};
    string       test_names [5] = '{"reset", "alu_lui", "branch_jal", "backpressure",
                                    "illegal_trap"};

    logic [31:0] cur_pc;
    logic [4:0]  cur_rd;
    logic [31:0] cur_data;
    logic        cur_trap;
    logic        cur_ill;
    int          cur_test;

    rv_core rv_core_inst (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1.
    endfunction

    function automatic logic [31:0] encode_instr(input op_kind_e kind, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                                 input logic [31:0] imm);
        case (kind)
            K_LUI:    return {imm[31:12], rd, 7'b0110111};
            K_ADDI:   return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_XORI:   return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            K_ADD:    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:    return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:    return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:     return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:    return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:    return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_JAL:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            K_BEQ:    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            K_EBREAK: return 32'h0010_0073;
            default:  return {imm[11:0], rs1, 3'b001, rd, 7'b0010011};  // SLLI is not supported.
        endcase
    endfunction

    task automatic place_instr(input int addr, input op_kind_e kind, input int rd,
                               input int rs1, input int rs2, input int imm);
        int w;
        w = addr / 4;
        prog_kind[w] = kind;
        prog_rd[w]   = 5'(rd);
        prog_rs1[w]  = 5'(rs1);
        prog_rs2[w]  = 5'(rs2);
        prog_imm[w]  = 32'(imm);
        mem[w]       = encode_instr(kind, 5'(rd), 5'(rs1), 5'(rs2), 32'(imm));
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i]       = 32'hbad0_0000 | 32'(i * 4);  // Filler tagged with its address.
            prog_kind[i] = K_ILL;
            prog_rd[i]   = '0;
            prog_rs1[i]  = '0;
            prog_rs2[i]  = '0;
            prog_imm[i]  = '0;
        end
        place_instr(32'h00, K_LUI,  1, 0, 0, 32'h12345000);
        place_instr(32'h04, K_ADDI, 2, 0, 0, 5);
        place_instr(32'h08, K_ADDI, 3, 2, 0, -7);       // Uses x2 from the line before.
        place_instr(32'h0c, K_XORI, 4, 3, 0, 32'h0f0);
        place_instr(32'h10, K_ADD,  5, 1, 2, 0);
        place_instr(32'h14, K_SUB,  6, 2, 3, 0);
        place_instr(32'h18, K_AND,  7, 4, 5, 0);
        place_instr(32'h1c, K_OR,   8, 6, 7, 0);
        place_instr(32'h20, K_XOR,  9, 8, 1, 0);
        place_instr(32'h24, K_SLT, 10, 3, 2, 0);
        place_instr(32'h28, K_SLT, 11, 2, 3, 0);
        place_instr(32'h2c, K_BEQ,  0, 6, 6, 8);        // Taken.
        place_instr(32'h30, K_ADDI, 12, 0, 0, 99);
        place_instr(32'h34, K_BNE,  0, 2, 2, 8);        // Not taken.
        place_instr(32'h38, K_BNE,  0, 2, 3, 8);
        place_instr(32'h3c, K_ADDI, 12, 0, 0, 77);
        place_instr(32'h40, K_JAL, 13, 0, 0, 8);
        place_instr(32'h44, K_ADDI, 12, 0, 0, 55);
        place_instr(32'h48, K_ADDI, 14, 0, 0, 11);
        place_instr(32'h4c, K_ILL, 14, 0, 0, 1);
        place_instr(32'h50, K_ADDI, 15, 14, 0, 0);      // Reads x14 after the illegal word.
        place_instr(32'h54, K_EBREAK, 0, 0, 0, 0);
        place_instr(32'h58, K_ADDI, 12, 0, 0, 33);
        place_instr(32'h100, K_ADDI, 16, 13, 0, 1);
        place_instr(32'h104, K_JAL, 0, 0, 0, 0);        // Handler parks here.
    endtask

    task automatic build_expected();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        writes;
        logic        seen_ill;
        int          w;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        pc       = rv_pkg::RESET_ADDR;
        seen_ill = 1'b0;
        for (int n = 0; n < N_REC; n++)
        begin
            w           = int'(pc[9:2]);
            a           = regs[prog_rs1[w]];
            b           = regs[prog_rs2[w]];
            imm         = prog_imm[w];
            res         = '0;
            next_pc     = pc + 32'd4;
            writes      = 1'b1;
            exp_trap[n] = 1'b0;
            exp_ill[n]  = 1'b0;
            case (prog_kind[w])
                K_LUI:  res = imm;
                K_ADDI: res = a + imm;
                K_XORI: res = a ^ imm;
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_JAL:
                begin
                    res     = pc + 32'd4;
                    next_pc = pc + imm;
                end
                K_BEQ:
                begin
                    writes = 1'b0;
                    if (a == b)
                        next_pc = pc + imm;
                end
                K_BNE:
                begin
                    writes = 1'b0;
                    if (a != b)
                        next_pc = pc + imm;
                end
                K_EBREAK:
                begin
                    writes      = 1'b0;
                    exp_trap[n] = 1'b1;
                    next_pc     = rv_pkg::TRAP_ADDR;
                end
                default:
                begin
                    writes     = 1'b0;
                    exp_ill[n] = 1'b1;
                    seen_ill   = 1'b1;
                end
            endcase
            writes      = writes && (prog_rd[w] != 5'd0);  // Nothing lands in x0.
            exp_pc[n]   = pc;
            exp_rd[n]   = writes ? prog_rd[w] : 5'd0;
            exp_data[n] = writes ? res : 32'd0;
            if (writes)
                regs[prog_rd[w]] = res;
            if (seen_ill || exp_trap[n] || pc >= rv_pkg::TRAP_ADDR)
                exp_test[n] = T_TRAP;
            else if (prog_kind[w] inside {K_JAL, K_BEQ, K_BNE})
                exp_test[n] = T_BRANCH;
            else
                exp_test[n] = T_ALU;
            pc = next_pc;
        end
        exp_test[N_REC] = T_ALU;
    endtask

    task automatic flag_mismatch(input int id, input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        test_errs[id]++;
        $display("MISMATCH %s %s: expected %h, actual %h", test_names[id], field, expected, actual);
    endtask

    task automatic flag_error(input int id, input string what);
        test_errs[id]++;
        $display("ERROR %s: %s", test_names[id], what);
    endtask

    task automatic summarize_test(input int id);
        if (test_errs[id] == 0)
        begin
            pass_count++;
            $display("test %s: ok", test_names[id]);
        end
        else
        begin
            fail_count++;
            $display("test %s: %0d errors", test_names[id], test_errs[id]);
        end
    endtask

    task automatic run_program(input logic use_random);
        @(negedge i_clk);
        i_rst      <= 1'b1;
        random_ack <= use_random;
        repeat (2) @(negedge i_clk);
        i_rst <= 1'b0;
        wait (chk_idx == N_REC);
    endtask

    // Memory model. Ack is forced after ACK_MAX_WAIT withheld cycles.
    always @(negedge i_clk)
    begin
        if (i_rst)
        begin
            i_ack         <= 1'b0;
            i_instruction <= '0;
            ack_wait      <= 0;
        end
        else
        begin
            ack_now = 1'b1;
            if (random_ack)
            begin
                lfsr    = lfsr_step(lfsr);
                ack_now = lfsr[0] || (ack_wait >= ACK_MAX_WAIT);
            end
            ack_wait      <= (o_cyc && !ack_now) ? ack_wait + 1 : 0;
            i_ack         <= ack_now;
            i_instruction <= mem[o_addr[9:2]];
        end
    end

    always @(posedge i_clk)
    begin
        rst_q <= i_rst;
        if (i_rst)
            chk_idx <= 0;
        else if (o_retire_valid)
            chk_idx <= chk_idx + 1;  // Next record becomes the queue head.
    end

    assign cur_pc   = exp_pc[chk_idx];
    assign cur_rd   = exp_rd[chk_idx];
    assign cur_data = exp_data[chk_idx];
    assign cur_trap = exp_trap[chk_idx];
    assign cur_ill  = exp_ill[chk_idx];
    assign cur_test = random_ack ? T_BP : exp_test[chk_idx];

    a_reset_quiet: assert property (@(posedge i_clk) rst_q |-> (!o_cyc && !o_retire_valid))
        else flag_error(random_ack ? T_BP : T_RESET, "bus request or retire during reset");
    a_first_cyc: assert property (@(posedge i_clk) (rst_q && !i_rst) |=> o_cyc)
        else flag_error(random_ack ? T_BP : T_RESET, "no bus request right after reset");
    a_first_addr: assert property (@(posedge i_clk) (rst_q && !i_rst) |=>
        (o_addr == rv_pkg::IADDR_BITS'(rv_pkg::RESET_ADDR)))
        else flag_mismatch(random_ack ? T_BP : T_RESET, "first addr",
                           rv_pkg::RESET_ADDR, 32'($sampled(o_addr)));

    a_retire_pc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_valid |-> (o_retire_pc == cur_pc))
        else flag_mismatch($sampled(cur_test), "pc", $sampled(cur_pc), $sampled(o_retire_pc));
    a_retire_rd: assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_valid |-> (o_retire_rd == cur_rd))
        else flag_mismatch($sampled(cur_test), "rd", $sampled(cur_rd), $sampled(o_retire_rd));
    a_retire_data: assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_valid |-> (o_retire_data == cur_data))
        else flag_mismatch($sampled(cur_test), "data", $sampled(cur_data),
                           $sampled(o_retire_data));
    a_retire_trap: assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_valid |-> (o_retire_trap == cur_trap))
        else flag_mismatch($sampled(cur_test), "trap", $sampled(cur_trap),
                           $sampled(o_retire_trap));
    a_retire_ill: assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_valid |-> (o_retire_illegal == cur_ill))
        else flag_mismatch($sampled(cur_test), "illegal", $sampled(cur_ill),
                           $sampled(o_retire_illegal));

    // Two full runs with up to ACK_MAX_WAIT + 1 cycles for each record.
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Timeout: the core stopped producing the expected retire records");
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        i_rst = 1'b1;
        load_program();
        build_expected();
        run_program(1'b0);
        summarize_test(T_RESET);
        summarize_test(T_ALU);
        summarize_test(T_BRANCH);
        summarize_test(T_TRAP);
        run_program(1'b1);  // Same program with ack withheld at random.
        summarize_test(T_BP);
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* rv_core.f */
common/rv_pkg.sv
common/rv_fetch_if.sv
common/rv_issue_if.sv
fetch/rv_fetch_buf.sv
fetch/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
test/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - common/rv_fetch_if.sv
  - common/rv_issue_if.sv
  - fetch/rv_fetch_buf.sv
  - fetch/rv_fetch.sv
  - logic/rv_decode.sv
  - logic/rv_execute.sv
  - logic/rv_result.sv
  - logic/rv_core.sv
  - target: test
    files:
      - test/tb_rv_core.sv
